// File: src/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define CSR_DATA_WIDTH 32

// --------------------
// Machine-mode CSR addresses
// --------------------
`define CSR_MSTATUS       12'h300
`define CSR_MISA          12'h301
`define CSR_MIE           12'h304
`define CSR_MTVEC         12'h305
`define CSR_MCOUNTEREN    12'h306
`define CSR_MCOUNTINHIBIT 12'h320
`define CSR_MSCRATCH      12'h340
`define CSR_MEPC          12'h341
`define CSR_MCAUSE        12'h342
`define CSR_MIP           12'h344
`define CSR_MCYCLE        12'hB00
`define CSR_MINSTRET      12'hB02
`define CSR_MCYCLEH       12'hB80
`define CSR_MINSTRETH     12'hB82

// MXL = 1 (RV32), I at bit 8, M at bit 12
`define CSR_MISA_VALUE    32'h4000_1100

// --------------------
// mstatus fields
// --------------------
`define MSTATUS_MIE_BIT   3
`define MSTATUS_MPIE_BIT  7

`endif

// File: src/CsrPkg.sv
`include "csr_params.svh"

package CsrPkg;

    // One CSR data word
    typedef logic [`CSR_DATA_WIDTH-1:0] CsrData;

    // 12-bit CSR address space
    typedef logic [11:0] CsrAddr;

    // Access kind requested by the core
    typedef enum logic [2:0]
    {
        CSR_OP_NONE  = 3'd0,   // No access
        CSR_OP_READ  = 3'd1,   // Read only
        CSR_OP_WRITE = 3'd2,   // Replace with operand
        CSR_OP_SET   = 3'd3,   // OR in operand bits
        CSR_OP_CLEAR = 3'd4    // Clear operand bits
    } CsrOp;

    // mcause layout, bit 31 flags an interrupt
    typedef logic [`CSR_DATA_WIDTH-1:0] CauseCode;

endpackage

// File: src/CsrBus.sv
`timescale 1ns/1ps

interface CsrBus;
    import CsrPkg::*;

    logic   strobe;   // One-cycle write enable
    CsrAddr addr;     // Target CSR
    CsrData wdata;    // Final value to store
    CsrData rdata;    // Zero unless hit
    logic   hit;      // Address owned by this block

    // Top level side
    modport master
    (
        output strobe,
        output addr,
        output wdata,
        input  rdata,
        input  hit
    );

    // Register block side
    modport slave
    (
        input  strobe,
        input  addr,
        input  wdata,
        output rdata,
        output hit
    );

endinterface

// File: src/CsrControlRegs.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module CsrControlRegs
(
    input  logic             i_clock,
    input  logic             i_rstN,
    CsrBus.slave             bus,
    input  logic             i_trap,
    input  CsrPkg::CsrData   i_trapPc,
    input  CsrPkg::CauseCode i_trapCause,
    input  logic             i_mret,
    output CsrPkg::CsrData   o_trapVector,
    output CsrPkg::CsrData   o_epc,
    output logic             o_irqEnable,
    output logic             o_inhibitCycle,
    output logic             o_inhibitInstret
);
    import CsrPkg::*;

    logic        mstatusMie;
    logic        mstatusMpie;
    logic [29:0] mtvecBase;
    logic [1:0]  mtvecMode;    // 0 direct, 1 vectored
    CsrData      mscratch;
    logic [29:0] mepcWord;     // Word aligned return pc
    CauseCode    mcause;
    logic [2:0]  mieBits;      // MEIE, MTIE, MSIE
    logic [2:0]  mcounteren;   // IR, TM, CY
    logic        inhibitCy;
    logic        inhibitIr;
    CsrData      baseAddr;

    // --------------------
    // Register update
    // --------------------
    always_ff @(posedge i_clock)
    begin
        if (!i_rstN)
        begin
            mstatusMie  <= 1'b0;
            mstatusMpie <= 1'b0;
            mtvecBase   <= '0;
            mtvecMode   <= 2'b00;
            mscratch    <= '0;
            mepcWord    <= '0;
            mcause      <= '0;
            mieBits     <= '0;
            mcounteren  <= '0;
            inhibitCy   <= 1'b1;   // Counters start stopped
            inhibitIr   <= 1'b1;
        end
        else
        begin
            if (bus.strobe)
            begin
                case (bus.addr)
                    `CSR_MSTATUS:
                    begin
                        mstatusMie  <= bus.wdata[`MSTATUS_MIE_BIT];
                        mstatusMpie <= bus.wdata[`MSTATUS_MPIE_BIT];
                    end
                    `CSR_MTVEC:
                    begin
                        mtvecBase <= bus.wdata[31:2];
                        if (!bus.wdata[1])                   // Modes 2 and 3 are reserved
                            mtvecMode <= bus.wdata[1:0];
                    end
                    `CSR_MSCRATCH:      mscratch   <= bus.wdata;
                    `CSR_MEPC:          mepcWord   <= bus.wdata[31:2];
                    `CSR_MCAUSE:        mcause     <= bus.wdata;
                    `CSR_MIE:           mieBits    <= {bus.wdata[11], bus.wdata[7], bus.wdata[3]};
                    `CSR_MCOUNTEREN:    mcounteren <= bus.wdata[2:0];
                    `CSR_MCOUNTINHIBIT:
                    begin
                        inhibitCy <= bus.wdata[0];
                        inhibitIr <= bus.wdata[2];
                    end
                    default: ;
                endcase
            end

            // Later assignments override a CSR write in the same cycle
            if (i_trap)
            begin
                mepcWord    <= i_trapPc[31:2];
                mcause      <= i_trapCause;
                mstatusMpie <= mstatusMie;
                mstatusMie  <= 1'b0;
            end
            else if (i_mret)
            begin
                mstatusMie  <= mstatusMpie;
                mstatusMpie <= 1'b1;
            end
        end
    end

    // --------------------
    // Read-back
    // --------------------
    always_comb
    begin
        bus.hit   = 1'b1;
        bus.rdata = '0;
        case (bus.addr)
            `CSR_MSTATUS:
            begin
                bus.rdata[`MSTATUS_MIE_BIT]  = mstatusMie;
                bus.rdata[`MSTATUS_MPIE_BIT] = mstatusMpie;
            end
            `CSR_MISA:          bus.rdata = `CSR_MISA_VALUE;
            `CSR_MIE:           bus.rdata = {20'b0, mieBits[2], 3'b0, mieBits[1],
                                             3'b0, mieBits[0], 3'b0};
            `CSR_MTVEC:         bus.rdata = {mtvecBase, mtvecMode};
            `CSR_MCOUNTEREN:    bus.rdata = {29'b0, mcounteren};
            `CSR_MCOUNTINHIBIT: bus.rdata = {29'b0, inhibitIr, 1'b0, inhibitCy};
            `CSR_MSCRATCH:      bus.rdata = mscratch;
            `CSR_MEPC:          bus.rdata = {mepcWord, 2'b00};
            `CSR_MCAUSE:        bus.rdata = mcause;
            `CSR_MIP:           bus.rdata = '0;   // No pending logic
            default:            bus.hit   = 1'b0;
        endcase
    end

    assign baseAddr = {mtvecBase, 2'b00};

    // Vectored mode only offsets interrupts
    assign o_trapVector = (mtvecMode == 2'b01 && mcause[31])
                        ? baseAddr + {mcause[29:0], 2'b00}
                        : baseAddr;

    assign o_epc            = {mepcWord, 2'b00};
    assign o_irqEnable      = mstatusMie;
    assign o_inhibitCycle   = inhibitCy;
    assign o_inhibitInstret = inhibitIr;

    // The core never traps and returns in the same cycle
    assert property (@(posedge i_clock) disable iff (!i_rstN) !(i_trap && i_mret))
        else $error("trap and mret strobed in the same cycle");

    // A reserved mode leaves the previous mode in place
    assert property (@(posedge i_clock) disable iff (!i_rstN)
        (bus.strobe && bus.addr == `CSR_MTVEC && bus.wdata[1]) |=> $stable(mtvecMode))
        else $error("mtvec mode changed on a reserved-mode write");

endmodule

// File: src/CsrCounters.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module CsrCounters
(
    input  logic i_clock,
    input  logic i_rstN,
    CsrBus.slave bus,
    input  logic i_instRet,
    input  logic i_inhibitCycle,
    input  logic i_inhibitInstret
);
    import CsrPkg::*;

    logic [63:0] cycleCount;
    logic [63:0] instretCount;
    logic        wrCycleLo;
    logic        wrCycleHi;
    logic        wrInstretLo;
    logic        wrInstretHi;

    // Written half wins, a high write lets the low half keep counting
    function automatic logic [63:0] nextCount
    (
        input logic [63:0] count,
        input logic        inc,
        input logic        wrLo,
        input logic        wrHi,
        input CsrData      data
    );
        logic [63:0] stepped;
        stepped = count + 64'(inc);
        if (wrLo)
            nextCount = {count[63:32], data};
        else if (wrHi)
            nextCount = {data, stepped[31:0]};
        else
            nextCount = stepped;
    endfunction

    assign wrCycleLo   = bus.strobe && (bus.addr == `CSR_MCYCLE);
    assign wrCycleHi   = bus.strobe && (bus.addr == `CSR_MCYCLEH);
    assign wrInstretLo = bus.strobe && (bus.addr == `CSR_MINSTRET);
    assign wrInstretHi = bus.strobe && (bus.addr == `CSR_MINSTRETH);

    // --------------------
    // Counter update
    // --------------------
    always_ff @(posedge i_clock)
    begin
        if (!i_rstN)
        begin
            cycleCount   <= '0;
            instretCount <= '0;
        end
        else
        begin
            cycleCount   <= nextCount(cycleCount, !i_inhibitCycle,
                                      wrCycleLo, wrCycleHi, bus.wdata);
            instretCount <= nextCount(instretCount, !i_inhibitInstret && i_instRet,
                                      wrInstretLo, wrInstretHi, bus.wdata);
        end
    end

    always_comb
    begin
        bus.hit   = 1'b1;
        bus.rdata = '0;
        case (bus.addr)
            `CSR_MCYCLE:    bus.rdata = cycleCount[31:0];
            `CSR_MCYCLEH:   bus.rdata = cycleCount[63:32];
            `CSR_MINSTRET:  bus.rdata = instretCount[31:0];
            `CSR_MINSTRETH: bus.rdata = instretCount[63:32];
            default:        bus.hit   = 1'b0;
        endcase
    end

    // Inhibit bits come from the control block
    assert property (@(posedge i_clock) disable iff (!i_rstN)
        (i_inhibitCycle && !(wrCycleLo || wrCycleHi)) |=> $stable(cycleCount))
        else $error("mcycle moved while inhibited");

    assert property (@(posedge i_clock) disable iff (!i_rstN)
        (i_inhibitInstret && !(wrInstretLo || wrInstretHi)) |=> $stable(instretCount))
        else $error("minstret moved while inhibited");

endmodule

// File: src/CsrUnit.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module CsrUnit
(
    input  logic             i_clock,
    input  logic             i_rstN,
    input  logic             i_valid,
    input  CsrPkg::CsrOp     i_op,
    input  CsrPkg::CsrAddr   i_addr,
    input  CsrPkg::CsrData   i_wdata,
    output CsrPkg::CsrData   o_rdata,
    output logic             o_illegal,
    input  logic             i_instRet,
    input  logic             i_trap,
    input  CsrPkg::CsrData   i_trapPc,
    input  CsrPkg::CauseCode i_trapCause,
    input  logic             i_mret,
    output CsrPkg::CsrData   o_trapVector,
    output CsrPkg::CsrData   o_epc,
    output logic             o_irqEnable
);
    import CsrPkg::*;

    CsrBus ctrlBus ();
    CsrBus cntBus ();

    logic   isWriteOp;
    logic   readOnly;
    logic   anyHit;
    logic   writeStrobe;
    logic   inhibitCycle;
    logic   inhibitInstret;
    CsrData newValue;

    // --------------------
    // Access decode
    // --------------------
    assign o_rdata   = ctrlBus.rdata | cntBus.rdata;   // Non-hitting block returns zero
    assign anyHit    = ctrlBus.hit | cntBus.hit;
    assign isWriteOp = i_op inside {CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR};
    assign readOnly  = (i_addr == `CSR_MISA) || (i_addr == `CSR_MIP);
    assign o_illegal = i_valid && (!anyHit || (isWriteOp && readOnly));

    // Read-modify-write on the current value
    always_comb
    begin
        case (i_op)
            CSR_OP_WRITE: newValue = i_wdata;
            CSR_OP_SET:   newValue = o_rdata | i_wdata;
            CSR_OP_CLEAR: newValue = o_rdata & ~i_wdata;
            default:      newValue = o_rdata;
        endcase
    end

    assign writeStrobe = i_valid && isWriteOp && !o_illegal;

    assign ctrlBus.strobe = writeStrobe;
    assign ctrlBus.addr   = i_addr;
    assign ctrlBus.wdata  = newValue;
    assign cntBus.strobe  = writeStrobe;
    assign cntBus.addr    = i_addr;
    assign cntBus.wdata   = newValue;

    // --------------------
    // Blocks
    // --------------------
    CsrControlRegs u_controlRegs
    (
        .i_clock          (i_clock),
        .i_rstN           (i_rstN),
        .bus              (ctrlBus),
        .i_trap           (i_trap),
        .i_trapPc         (i_trapPc),
        .i_trapCause      (i_trapCause),
        .i_mret           (i_mret),
        .o_trapVector     (o_trapVector),
        .o_epc            (o_epc),
        .o_irqEnable      (o_irqEnable),
        .o_inhibitCycle   (inhibitCycle),
        .o_inhibitInstret (inhibitInstret)
    );

    CsrCounters u_counters
    (
        .i_clock          (i_clock),
        .i_rstN           (i_rstN),
        .bus              (cntBus),
        .i_instRet        (i_instRet),
        .i_inhibitCycle   (inhibitCycle),
        .i_inhibitInstret (inhibitInstret)
    );

    // Address maps of the two blocks are disjoint
    assert property (@(posedge i_clock) disable iff (!i_rstN) !(ctrlBus.hit && cntBus.hit))
        else $error("both CSR blocks claim address %h", i_addr);

endmodule

// File: sim/tb_CsrUnit.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module tb_CsrUnit;
    import CsrPkg::*;

    logic     i_clock;
    logic     i_rstN;
    logic     i_valid;
    CsrOp     i_op;
    CsrAddr   i_addr;
    CsrData   i_wdata;
    CsrData   o_rdata;
    logic     o_illegal;
    logic     i_instRet;
    logic     i_trap;
    CsrData   i_trapPc;
    CauseCode i_trapCause;
    logic     i_mret;
    CsrData   o_trapVector;
    CsrData   o_epc;
    logic     o_irqEnable;

    CsrData   lcgState     = 32'd56431;
    int       errorCount   = 0;
    int       checkCount   = 0;
    int       testsRun     = 0;
    int       testsFailed  = 0;
    int       errorsBefore = 0;

    CsrUnit i_dut (.*);

    initial
    begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;   // 4 ns period
    end

    // --------------------
    // Stimulus helpers
    // --------------------
    function automatic CsrData lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic CsrOp randomOp();
        case ((lcgNext() >> 16) % 32'd3)   // Upper bits have the longer period
            32'd0:   return CSR_OP_WRITE;
            32'd1:   return CSR_OP_SET;
            default: return CSR_OP_CLEAR;
        endcase
    endfunction

    // Expected register value after one access
    function automatic CsrData csrModel
    (
        input CsrOp   op,
        input CsrData oldValue,
        input CsrData operand
    );
        case (op)
            CSR_OP_WRITE: return operand;
            CSR_OP_SET:   return oldValue | operand;
            CSR_OP_CLEAR: return oldValue & ~operand;
            default:      return oldValue;
        endcase
    endfunction

    task automatic checkData(input string name, input CsrData got, input CsrData expected);
        checkCount++;
        if (got !== expected)
        begin
            errorCount++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic expected);
        checkCount++;
        if (got !== expected)
        begin
            errorCount++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, expected);
        end
    endtask

    // One access per falling edge, outputs sampled 1 ns later
    task automatic driveAccess(input logic valid, input CsrOp op, input CsrAddr addr,
                               input CsrData data);
        @(negedge i_clock);
        i_valid   = valid;
        i_op      = op;
        i_addr    = addr;
        i_wdata   = data;
        i_instRet = 1'b0;
        i_trap    = 1'b0;
        i_mret    = 1'b0;
        #1;
    endtask

    task automatic idleCycle();
        driveAccess(1'b0, CSR_OP_NONE, '0, '0);
    endtask

    task automatic readCsr(input CsrAddr addr, output CsrData data, output logic illegal);
        driveAccess(1'b1, CSR_OP_READ, addr, '0);
        data    = o_rdata;
        illegal = o_illegal;
    endtask

    task automatic writeCsr(input CsrOp op, input CsrAddr addr, input CsrData data,
                            output logic illegal);
        driveAccess(1'b1, op, addr, data);
        illegal = o_illegal;
    endtask

    task automatic expectRead(input string name, input CsrAddr addr, input CsrData expected);
        CsrData data;
        logic   illegal;
        readCsr(addr, data, illegal);
        checkData(name, data, expected);
        checkFlag({name, " illegal"}, illegal, 1'b0);
    endtask

    // Trap when trap is high, mret otherwise
    task automatic strobeTrapControl(input logic trap, input CsrData pc, input CauseCode cause);
        @(negedge i_clock);
        i_valid     = 1'b0;
        i_trap      = trap;
        i_mret      = !trap;
        i_trapPc    = pc;
        i_trapCause = cause;
        idleCycle();
    endtask

    task automatic waitCycleCounting();
        CsrData first;
        CsrData now;
        logic   illegal;
        int     cycles;
        readCsr(`CSR_MCYCLE, first, illegal);
        now    = first;
        cycles = 0;
        while (now == first && cycles < 20)
        begin
            readCsr(`CSR_MCYCLE, now, illegal);
            cycles++;
        end
        if (now == first)
        begin
            errorCount++;
            $display("Timeout: mcycle did not start counting within 20 cycles");
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount == errorsBefore)
            $display("Test %s: ok", name);
        else
        begin
            testsFailed++;
            $display("Test %s: FAILED with %0d errors", name, errorCount - errorsBefore);
        end
        errorsBefore = errorCount;
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial
    begin : stimulus
        CsrData   shadow;
        CsrData   value;
        CsrData   expected;
        CsrData   base;
        CsrData   pc;
        CsrData   lo;
        CsrData   expVec;
        CauseCode cause;
        CsrOp     op;
        logic     illegal;
        int       n;
        int       k;

        i_rstN      = 1'b0;
        i_valid     = 1'b0;
        i_op        = CSR_OP_NONE;
        i_addr      = '0;
        i_wdata     = '0;
        i_instRet   = 1'b0;
        i_trap      = 1'b0;
        i_trapPc    = '0;
        i_trapCause = '0;
        i_mret      = 1'b0;
        repeat (4) @(posedge i_clock);
        @(negedge i_clock);
        i_rstN = 1'b1;

        idleCycle();
        checkFlag("o_illegal while idle", o_illegal, 1'b0);
        expectRead("mstatus", `CSR_MSTATUS, '0);
        expectRead("mscratch", `CSR_MSCRATCH, '0);
        expectRead("mtvec", `CSR_MTVEC, '0);
        expectRead("mepc", `CSR_MEPC, '0);
        expectRead("mcause", `CSR_MCAUSE, '0);
        expectRead("mcounteren", `CSR_MCOUNTEREN, '0);
        expectRead("mcountinhibit", `CSR_MCOUNTINHIBIT, 32'd5);
        expectRead("misa", `CSR_MISA, `CSR_MISA_VALUE);
        repeat (4)
        begin
            @(negedge i_clock);
            i_valid   = 1'b0;
            i_instRet = 1'b1;   // Must not count while inhibited
        end
        expectRead("mcycle stopped", `CSR_MCYCLE, '0);
        expectRead("mcycleh stopped", `CSR_MCYCLEH, '0);
        expectRead("minstret stopped", `CSR_MINSTRET, '0);
        finishTest("reset values");

        shadow = '0;
        repeat (40)
        begin
            op    = randomOp();
            value = lcgNext();
            writeCsr(op, `CSR_MSCRATCH, value, illegal);
            shadow = csrModel(op, shadow, value);
            expectRead("mscratch", `CSR_MSCRATCH, shadow);
        end
        finishTest("mscratch read-modify-write");

        readCsr(12'h7C0, value, illegal);
        checkData("unknown address data", value, '0);
        checkFlag("unknown address illegal", illegal, 1'b1);
        writeCsr(CSR_OP_WRITE, `CSR_MISA, lcgNext(), illegal);
        checkFlag("misa write illegal", illegal, 1'b1);
        expectRead("misa after write", `CSR_MISA, `CSR_MISA_VALUE);
        writeCsr(CSR_OP_SET, `CSR_MIP, 32'h888, illegal);
        checkFlag("mip set illegal", illegal, 1'b1);
        expectRead("mip", `CSR_MIP, '0);
        writeCsr(CSR_OP_WRITE, `CSR_MSCRATCH, shadow, illegal);
        checkFlag("mscratch write illegal", illegal, 1'b0);
        finishTest("illegal accesses");

        writeCsr(CSR_OP_WRITE, `CSR_MCOUNTINHIBIT, '0, illegal);
        waitCycleCounting();
        value = lcgNext() & 32'h7FFF_FFFF;   // Keeps the low half clear of a carry
        writeCsr(CSR_OP_WRITE, `CSR_MCYCLE, value, illegal);
        expected = csrModel(CSR_OP_WRITE, '0, value);
        expectRead("mcycle after write", `CSR_MCYCLE, expected);
        n = 5 + int'((lcgNext() >> 16) % 32'd8);
        repeat (n - 1) idleCycle();
        expectRead("mcycle after N cycles", `CSR_MCYCLE, expected + CsrData'(n));
        readCsr(`CSR_MINSTRET, lo, illegal);
        k = 0;
        repeat (24)
        begin
            value = lcgNext();
            @(negedge i_clock);
            i_valid   = 1'b0;
            i_instRet = value[20];
            if (value[20])
                k++;
        end
        idleCycle();
        expectRead("minstret", `CSR_MINSTRET, lo + CsrData'(k));
        readCsr(`CSR_MCYCLE, lo, illegal);
        value = lcgNext();
        writeCsr(CSR_OP_WRITE, `CSR_MCYCLEH, value, illegal);
        expectRead("mcycleh after write", `CSR_MCYCLEH, value);
        expectRead("mcycle beside mcycleh write", `CSR_MCYCLE, lo + 32'd3);
        finishTest("counters");

        base = lcgNext() & ~32'h3;
        writeCsr(CSR_OP_WRITE, `CSR_MTVEC, base | 32'h1, illegal);   // Vectored mode
        writeCsr(CSR_OP_SET, `CSR_MSTATUS, 32'h1 << `MSTATUS_MIE_BIT, illegal);
        idleCycle();
        checkFlag("o_irqEnable before trap", o_irqEnable, 1'b1);
        value = lcgNext();
        cause = {value[31], 27'b0, value[3:0]};
        pc    = lcgNext();
        strobeTrapControl(1'b1, pc, cause);
        expVec = cause[31] ? base + ((cause & 32'h7FFF_FFFF) << 2) : base;
        checkFlag("o_irqEnable after trap", o_irqEnable, 1'b0);
        checkData("o_trapVector", o_trapVector, expVec);
        expectRead("mepc", `CSR_MEPC, pc & ~32'h3);
        expectRead("mcause", `CSR_MCAUSE, cause);
        expectRead("mstatus after trap", `CSR_MSTATUS, 32'h1 << `MSTATUS_MPIE_BIT);
        strobeTrapControl(1'b0, '0, '0);
        checkFlag("o_irqEnable after mret", o_irqEnable, 1'b1);
        checkData("o_epc", o_epc, pc & ~32'h3);
        expectRead("mstatus after mret", `CSR_MSTATUS,
                   (32'h1 << `MSTATUS_MIE_BIT) | (32'h1 << `MSTATUS_MPIE_BIT));
        finishTest("trap and return");

        repeat (8)
        begin
            readCsr(`CSR_MTVEC, shadow, illegal);
            op    = randomOp();
            value = (lcgNext() & ~32'h3) | 32'h2;   // Reserved mode 2
            writeCsr(op, `CSR_MTVEC, value, illegal);
            expected = csrModel(op, shadow, value);
            if (expected[1])
                expected[1:0] = shadow[1:0];   // Reserved mode keeps the old one
            expectRead("mtvec", `CSR_MTVEC, expected);
        end
        finishTest("mtvec mode legality");

        idleCycle();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+src
src/CsrPkg.sv
src/CsrBus.sv
src/CsrControlRegs.sv
src/CsrCounters.sv
src/CsrUnit.sv
sim/tb_CsrUnit.sv

// File: Makefile
SOURCES = project.f src/csr_params.svh src/CsrPkg.sv src/CsrBus.sv \
          src/CsrControlRegs.sv src/CsrCounters.sv src/CsrUnit.sv sim/tb_CsrUnit.sv

.PHONY: all run clean

all: obj_dir/Vtb_CsrUnit

obj_dir/Vtb_CsrUnit: $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_CsrUnit -f project.f -o Vtb_CsrUnit

run: obj_dir/Vtb_CsrUnit
	obj_dir/Vtb_CsrUnit > sim.log 2>&1 || true
	cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
